//--- files.f
hdl/mapperPkg.sv
hdl/tileLocate.sv
hdl/arenaMap.sv
hdl/pixelShade.sv
hdl/colorMapper.sv
tb/mapperChk.sv
tb/mapperScoreboard.sv
tb/colorMapperTb.sv

//--- hdl/arenaMap.sv
// arenaMap: stage two, tile map storage, tile type lookup and brick clearing
`timescale 1ns/1ps

module arenaMap (
	input logic Clk,
	input logic rstN,
	input mapperPkg::tileHitT hitData,
	input logic hitValid,
	output logic hitReady,
	input mapperPkg::sceneT scene,
	output mapperPkg::shadeReqT shadeData,
	output logic shadeValid,
	input logic shadeReady
);

	mapperPkg::tileE tiles [mapperPkg::TileRows][mapperPkg::TileCols];

	logic inGrid;
	logic accept;
	logic clearBrick;
	mapperPkg::tileE curTile;

	// tile type of the reset layout
	function automatic mapperPkg::tileE layoutTile(input int col, input int row);
		mapperPkg::tileE t;
		if (col == 0 || row == 0 || col == mapperPkg::TileCols - 1 ||
			row == mapperPkg::TileRows - 1 || (col % 2 == 0 && row % 2 == 0)) begin
			t = mapperPkg::tileWall;
		end else if (col == mapperPkg::SpeedUpCol && row == mapperPkg::SpeedUpRow) begin
			t = mapperPkg::tileSpeedUp;
		end else if (col == mapperPkg::BombUpCol && row == mapperPkg::BombUpRow) begin
			t = mapperPkg::tileBombUp;
		end else if ((col + row) % 3 == 0) begin
			t = mapperPkg::tileBrick;
		end else begin
			t = mapperPkg::tileEmpty;
		end
		return t;
	endfunction

	// --------------------------------------------------
	// combinational read at the stage input
	// --------------------------------------------------
	assign inGrid = (hitData.col < mapperPkg::TileCols) && (hitData.row < mapperPkg::TileRows);

	// anything right of or below the grid reads as wall
	assign curTile = inGrid ? tiles[hitData.row][hitData.col] : mapperPkg::tileWall;

	assign hitReady = !shadeValid || shadeReady;
	assign accept = hitValid && hitReady;

	// blast pixel on a brick destroys it, never while paused
	assign clearBrick = accept && inGrid && hitData.pix.active &&
		(scene.gameState == mapperPkg::gamePlay) && hitData.blastHit &&
		(curTile == mapperPkg::tileBrick);

	// map storage, reloaded with the layout on reset
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int r = 0; r < mapperPkg::TileRows; r++) begin
				for (int c = 0; c < mapperPkg::TileCols; c++) begin
					tiles[r][c] <= layoutTile(c, r);
				end
			end
		end else if (clearBrick) begin
			tiles[hitData.row][hitData.col] <= mapperPkg::tileEmpty;
		end
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			shadeValid <= 1'b0;
		end else if (hitReady) begin
			shadeValid <= hitValid;
		end
	end

	// tile type as read before any clear, so the blast pixel itself still sees the brick
	always_ff @(posedge Clk) begin
		if (accept) begin
			shadeData.hit <= hitData;
			shadeData.tile <= curTile;
		end
	end

endmodule

//--- hdl/colorMapper.sv
// colorMapper: top level chaining tileLocate, arenaMap and pixelShade
`timescale 1ns/1ps

module colorMapper #(
	parameter int unsigned PlayerWidth = 20,
	parameter int unsigned PlayerHeight = 27,
	parameter int unsigned BombWidth = 15,
	parameter int unsigned BombHeight = 18
) (
	input logic Clk,
	input logic rstN,
	input mapperPkg::pixelReqT inReq,
	input logic inValid,
	output logic inReady,
	input mapperPkg::sceneT scene,
	output mapperPkg::rgbT outRgb,
	output logic outValid,
	input logic outReady
);

	mapperPkg::tileHitT hitData;
	logic hitValid;
	logic hitReady;
	mapperPkg::shadeReqT shadeData;
	logic shadeValid;
	logic shadeReady;

	// --------------------------------------------------
	// three stages, one cycle each
	// --------------------------------------------------
	tileLocate #(
		.PlayerWidth(PlayerWidth),
		.PlayerHeight(PlayerHeight),
		.BombWidth(BombWidth),
		.BombHeight(BombHeight)
	) locate (
		.Clk(Clk),
		.rstN(rstN),
		.inReq(inReq),
		.inValid(inValid),
		.inReady(inReady),
		.scene(scene),
		.hitData(hitData),
		.hitValid(hitValid),
		.hitReady(hitReady)
	);

	arenaMap arena (
		.Clk(Clk),
		.rstN(rstN),
		.hitData(hitData),
		.hitValid(hitValid),
		.hitReady(hitReady),
		.scene(scene),
		.shadeData(shadeData),
		.shadeValid(shadeValid),
		.shadeReady(shadeReady)
	);

	pixelShade shade (
		.Clk(Clk),
		.rstN(rstN),
		.shadeData(shadeData),
		.shadeValid(shadeValid),
		.shadeReady(shadeReady),
		.scene(scene),
		.outRgb(outRgb),
		.outValid(outValid),
		.outReady(outReady)
	);

endmodule

//--- hdl/mapperPkg.sv
// grid constants, banner bounds, palette, layout positions, enums and packed structs
package mapperPkg;

	// --------------------------------------------------
	// arena grid
	// --------------------------------------------------
	localparam int TileCols = 20;
	localparam int TileRows = 15;
	// 32-pixel tiles
	localparam int TileShift = 5;
	localparam int CoordW = 10;

	// pause banner, end exclusive
	localparam int BannerX0 = 173;
	localparam int BannerX1 = 467;
	localparam int BannerY0 = 220;
	localparam int BannerY1 = 261;

	// power-up tiles of the reset layout
	localparam int SpeedUpCol = 3;
	localparam int SpeedUpRow = 1;
	localparam int BombUpCol = 16;
	localparam int BombUpRow = 13;

	// --------------------------------------------------
	// enums
	// --------------------------------------------------
	// reset layout, by tile coordinates col and row:
	// border or both coordinates even -> wall,
	// else the two power-up positions -> that power-up,
	// else (col + row) mod 3 == 0 -> brick,
	// else empty
	typedef enum logic [2:0] {
		tileEmpty,
		tileWall,
		tileBrick,
		tileSpeedUp,
		tileBombUp
	} tileE;

	typedef enum logic [1:0] {
		bombIdle,
		bombArmed,
		bombExploding
	} bombStateE;

	typedef enum logic {
		gamePlay,
		gamePause
	} gameStateE;

	// --------------------------------------------------
	// structs
	// --------------------------------------------------
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbT;

	typedef struct packed {
		logic [CoordW-1:0] x;
		logic [CoordW-1:0] y;
		logic active;
	} pixelReqT;

	typedef struct packed {
		logic [CoordW-1:0] x;
		logic [CoordW-1:0] y;
		bombStateE state;
	} bombT;

	typedef struct packed {
		gameStateE gameState;
		logic [CoordW-1:0] player1X;
		logic [CoordW-1:0] player1Y;
		logic [CoordW-1:0] player2X;
		logic [CoordW-1:0] player2Y;
		bombT bomb1;
		bombT bomb2;
	} sceneT;

	typedef struct packed {
		pixelReqT pix;
		logic [CoordW-TileShift-1:0] col;
		logic [$clog2(TileRows)-1:0] row;
		logic player1Hit;
		logic player2Hit;
		logic bomb1Hit;
		logic bomb2Hit;
		logic blastHit;
		logic bannerHit;
	} tileHitT;

	typedef struct packed {
		tileHitT hit;
		tileE tile;
	} shadeReqT;

	// flat palette
	localparam rgbT ColorSky = 24'h00a2e8;
	localparam rgbT ColorWall = 24'hb0b0b0;
	localparam rgbT ColorBrick = 24'hb53120;
	localparam rgbT ColorBlast = 24'hffb62a;
	localparam rgbT ColorSpeedUp = 24'hf32424;
	localparam rgbT ColorBombUp = 24'h30a058;
	localparam rgbT ColorPlayer1 = 24'he82050;
	localparam rgbT ColorPlayer2 = 24'he01898;
	localparam rgbT ColorBomb = 24'h204058;
	localparam rgbT ColorBanner = 24'hffffff;
	localparam rgbT ColorBlack = 24'h000000;

endpackage

//--- hdl/pixelShade.sv
// pixelShade: stage three, layer priority and output colour register
`timescale 1ns/1ps

module pixelShade (
	input logic Clk,
	input logic rstN,
	input mapperPkg::shadeReqT shadeData,
	input logic shadeValid,
	output logic shadeReady,
	input mapperPkg::sceneT scene,
	output mapperPkg::rgbT outRgb,
	output logic outValid,
	input logic outReady
);

	mapperPkg::tileHitT hit;
	mapperPkg::tileE tile;
	mapperPkg::rgbT nextRgb;

	assign hit = shadeData.hit;
	assign tile = shadeData.tile;

	// --------------------------------------------------
	// layer priority, first match wins
	// --------------------------------------------------
	always_comb begin
		if (!hit.pix.active) begin
			nextRgb = mapperPkg::ColorBlack;
		end else if (scene.gameState == mapperPkg::gamePause) begin
			// pause screen is black apart from the banner
			if (hit.bannerHit) begin
				nextRgb = mapperPkg::ColorBanner;
			end else begin
				nextRgb = mapperPkg::ColorBlack;
			end
		end else if (tile == mapperPkg::tileWall) begin
			nextRgb = mapperPkg::ColorWall;
		end else if (hit.blastHit) begin
			// walls already taken above
			nextRgb = mapperPkg::ColorBlast;
		end else if (tile == mapperPkg::tileBrick) begin
			// bricks hide players and bombs
			nextRgb = mapperPkg::ColorBrick;
		end else if (hit.player1Hit) begin
			nextRgb = mapperPkg::ColorPlayer1;
		end else if (hit.player2Hit) begin
			nextRgb = mapperPkg::ColorPlayer2;
		end else if (hit.bomb1Hit) begin
			nextRgb = mapperPkg::ColorBomb;
		end else if (hit.bomb2Hit) begin
			nextRgb = mapperPkg::ColorBomb;
		end else if (tile == mapperPkg::tileSpeedUp) begin
			nextRgb = mapperPkg::ColorSpeedUp;
		end else if (tile == mapperPkg::tileBombUp) begin
			nextRgb = mapperPkg::ColorBombUp;
		end else begin
			nextRgb = mapperPkg::ColorSky;
		end
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	assign shadeReady = !outValid || outReady;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (shadeReady) begin
			outValid <= shadeValid;
		end
	end

	always_ff @(posedge Clk) begin
		if (shadeReady && shadeValid) begin
			outRgb <= nextRgb;
		end
	end

endmodule

//--- hdl/tileLocate.sv
// tileLocate: stage one, pixel to tile coordinates and object hit flags
`timescale 1ns/1ps

module tileLocate #(
	parameter int unsigned PlayerWidth = 20,
	parameter int unsigned PlayerHeight = 27,
	parameter int unsigned BombWidth = 15,
	parameter int unsigned BombHeight = 18
) (
	input logic Clk,
	input logic rstN,
	input mapperPkg::pixelReqT inReq,
	input logic inValid,
	output logic inReady,
	input mapperPkg::sceneT scene,
	output mapperPkg::tileHitT hitData,
	output logic hitValid,
	input logic hitReady
);

	localparam int IdxW = mapperPkg::CoordW - mapperPkg::TileShift;

	logic [IdxW-1:0] pixCol;
	logic [IdxW-1:0] pixRow;
	mapperPkg::tileHitT nextHit;

	// solid box test, offset wraps so pixels left of or above the box miss
	function automatic logic boxHit(
		input logic [mapperPkg::CoordW-1:0] px, py, ox, oy,
		input int unsigned w, h);
		logic [mapperPkg::CoordW-1:0] offX;
		logic [mapperPkg::CoordW-1:0] offY;
		offX = px - ox;
		offY = py - oy;
		return (offX < w) && (offY < h);
	endfunction

	// bomb tile plus its four neighbours
	function automatic logic inCross(
		input mapperPkg::bombT bomb,
		input logic [IdxW-1:0] col, row);
		logic [IdxW-1:0] bCol;
		logic [IdxW-1:0] bRow;
		logic sameCol;
		logic sameRow;
		bCol = bomb.x[mapperPkg::CoordW-1:mapperPkg::TileShift];
		bRow = bomb.y[mapperPkg::CoordW-1:mapperPkg::TileShift];
		sameCol = (col == bCol) && (row == bRow || row == bRow + 1'b1 || row + 1'b1 == bRow);
		sameRow = (row == bRow) && (col == bCol + 1'b1 || col + 1'b1 == bCol);
		return (bomb.state == mapperPkg::bombExploding) && (sameCol || sameRow);
	endfunction

	assign pixCol = inReq.x[mapperPkg::CoordW-1:mapperPkg::TileShift];
	assign pixRow = inReq.y[mapperPkg::CoordW-1:mapperPkg::TileShift];

	always_comb begin
		nextHit.pix = inReq;
		nextHit.col = pixCol;
		nextHit.row = pixRow[$bits(nextHit.row)-1:0];
		nextHit.player1Hit = boxHit(inReq.x, inReq.y, scene.player1X, scene.player1Y,
			PlayerWidth, PlayerHeight);
		nextHit.player2Hit = boxHit(inReq.x, inReq.y, scene.player2X, scene.player2Y,
			PlayerWidth, PlayerHeight);
		// bombs only drawn while armed
		nextHit.bomb1Hit = (scene.bomb1.state == mapperPkg::bombArmed) &&
			boxHit(inReq.x, inReq.y, scene.bomb1.x, scene.bomb1.y, BombWidth, BombHeight);
		nextHit.bomb2Hit = (scene.bomb2.state == mapperPkg::bombArmed) &&
			boxHit(inReq.x, inReq.y, scene.bomb2.x, scene.bomb2.y, BombWidth, BombHeight);
		nextHit.blastHit = inCross(scene.bomb1, pixCol, pixRow) ||
			inCross(scene.bomb2, pixCol, pixRow);
		nextHit.bannerHit = (inReq.x >= mapperPkg::BannerX0) && (inReq.x < mapperPkg::BannerX1) &&
			(inReq.y >= mapperPkg::BannerY0) && (inReq.y < mapperPkg::BannerY1);
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	assign inReady = !hitValid || hitReady;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			hitValid <= 1'b0;
		end else if (inReady) begin
			hitValid <= inValid;
		end
	end

	always_ff @(posedge Clk) begin
		if (inReady && inValid) begin
			hitData <= nextHit;
		end
	end

endmodule

//--- tb/colorMapperTb.sv
// colorMapperTb: clock, reset, pixel stimulus, back-pressure, test sequence and final report
`timescale 1ns/1ps

module colorMapperTb;

	localparam int PlayerW = 20;
	localparam int PlayerH = 27;
	localparam int BombW = 15;
	localparam int BombH = 18;
	localparam int WaitLimit = 200;
	// far enough that no box offset wraps onto the screen
	localparam int Off = 700;

	logic Clk;
	logic rstN;
	mapperPkg::pixelReqT inReq;
	logic inValid;
	logic inReady;
	mapperPkg::sceneT scene;
	mapperPkg::rgbT outRgb;
	logic outValid;
	logic outReady;

	logic [31:0] rngState;
	logic stallOn;
	int checkCount;
	int errorCount;
	int pending;
	int lastChecks;
	int lastErrors;

	colorMapper #(
		.PlayerWidth(PlayerW),
		.PlayerHeight(PlayerH),
		.BombWidth(BombW),
		.BombHeight(BombH)
	) UUT (
		.Clk(Clk),
		.rstN(rstN),
		.inReq(inReq),
		.inValid(inValid),
		.inReady(inReady),
		.scene(scene),
		.outRgb(outRgb),
		.outValid(outValid),
		.outReady(outReady)
	);

	mapperScoreboard #(
		.PlayerWidth(PlayerW),
		.PlayerHeight(PlayerH),
		.BombWidth(BombW),
		.BombHeight(BombH)
	) board (
		.Clk(Clk),
		.rstN(rstN),
		.checkCount(checkCount),
		.errorCount(errorCount),
		.pending(pending)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic int randBelow(input int range);
		rngState = xorshift(rngState);
		return rngState % range;
	endfunction

	task automatic abortOnTimeout(input string what);
		$display("Timeout: no progress while waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	// one clock, inputs change 1 ns after the edge
	task automatic stepCycle();
		@(posedge Clk);
		#1;
		if (stallOn) begin
			outReady = (randBelow(8) > 2);
		end
	endtask

	task automatic sendPixel(input int x, input int y, input logic act);
		logic taken;
		int waited;
		inReq.x = x[mapperPkg::CoordW-1:0];
		inReq.y = y[mapperPkg::CoordW-1:0];
		inReq.active = act;
		inValid = 1'b1;
		taken = 1'b0;
		waited = 0;
		while (!taken) begin
			// ready is settled by the falling edge
			@(negedge Clk);
			taken = inReady;
			stepCycle();
			waited++;
			if (!taken && waited > WaitLimit) begin
				abortOnTimeout("the input handshake");
			end
		end
		inValid = 1'b0;
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		while (pending != 0) begin
			stepCycle();
			waited++;
			if (waited > WaitLimit) begin
				abortOnTimeout("the pipeline to drain");
			end
		end
	endtask

	// mode 0 inactive, 1 active, 2 mostly active
	task automatic sendRandom(input int n, input int x0, input int w, input int y0,
		input int h, input int mode);
		int x;
		int y;
		for (int i = 0; i < n; i++) begin
			x = x0 + randBelow(w);
			y = y0 + randBelow(h);
			sendPixel(x, y, (mode == 2) ? (randBelow(4) != 0) : (mode == 1));
		end
	endtask

	task automatic sweepCross(input int col, input int row, input logic act);
		int cols [5];
		int rows [5];
		cols = '{col, col - 1, col + 1, col, col};
		rows = '{row, row, row, row - 1, row + 1};
		for (int t = 0; t < 5; t++) begin
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++) begin
					sendPixel(cols[t] * 32 + i * 8 + 3, rows[t] * 32 + j * 8 + 3, act);
				end
			end
		end
	endtask

	task automatic placeScene(input mapperPkg::gameStateE gs, input int p1x, p1y, p2x, p2y,
		input int b1x, b1y, input mapperPkg::bombStateE b1s,
		input int b2x, b2y, input mapperPkg::bombStateE b2s);
		scene.gameState = gs;
		scene.player1X = p1x[mapperPkg::CoordW-1:0];
		scene.player1Y = p1y[mapperPkg::CoordW-1:0];
		scene.player2X = p2x[mapperPkg::CoordW-1:0];
		scene.player2Y = p2y[mapperPkg::CoordW-1:0];
		scene.bomb1 = '{b1x[mapperPkg::CoordW-1:0], b1y[mapperPkg::CoordW-1:0], b1s};
		scene.bomb2 = '{b2x[mapperPkg::CoordW-1:0], b2y[mapperPkg::CoordW-1:0], b2s};
	endtask

	task automatic reportTest(input int num, input string name);
		$display("test %0d %s: %0d pixels checked, %0d mismatches", num, name,
			checkCount - lastChecks, errorCount - lastErrors);
		lastChecks = checkCount;
		lastErrors = errorCount;
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		rstN = 1'b0;
		inReq = '0;
		inValid = 1'b0;
		outReady = 1'b1;
		stallOn = 1'b0;
		rngState = 32'h9743;
		lastChecks = 0;
		lastErrors = 0;
		placeScene(mapperPkg::gamePlay, Off, Off, Off, Off,
			Off, Off, mapperPkg::bombIdle, Off, Off, mapperPkg::bombIdle);
		repeat (5) @(posedge Clk);
		#1;
		rstN = 1'b1;

		sendRandom(300, 0, 640, 0, 480, 1);
		drainPipe();
		reportTest(1, "arena layout");

		// player2 beside player1 and partly on a brick
		// bomb1 partly under player1, bomb2 on the speed-up
		placeScene(mapperPkg::gamePlay, 36, 34, 50, 34,
			44, 48, mapperPkg::bombArmed, 100, 40, mapperPkg::bombArmed);
		sendRandom(400, 32, 96, 32, 32, 1);
		drainPipe();
		reportTest(2, "overlays");

		// cross at tile 1,4 holds two walls and one brick
		placeScene(mapperPkg::gamePlay, Off, Off, Off, Off,
			40, 136, mapperPkg::bombExploding, Off, Off, mapperPkg::bombIdle);
		sweepCross(1, 4, 1'b1);
		drainPipe();
		placeScene(mapperPkg::gamePlay, Off, Off, Off, Off,
			40, 136, mapperPkg::bombIdle, Off, Off, mapperPkg::bombIdle);
		sweepCross(1, 4, 1'b1);
		drainPipe();
		reportTest(3, "blast and destruction");

		placeScene(mapperPkg::gamePause, 36, 34, 70, 34,
			100, 70, mapperPkg::bombExploding, Off, Off, mapperPkg::bombIdle);
		sweepCross(3, 2, 1'b1);
		sendRandom(150, 150, 340, 200, 80, 1);
		drainPipe();
		// brick at 3,3 has to survive the paused blast
		placeScene(mapperPkg::gamePlay, Off, Off, Off, Off,
			100, 70, mapperPkg::bombIdle, Off, Off, mapperPkg::bombIdle);
		sweepCross(3, 2, 1'b1);
		drainPipe();
		reportTest(4, "pause");

		placeScene(mapperPkg::gamePlay, 36, 34, 70, 34,
			100, 70, mapperPkg::bombExploding, 44, 44, mapperPkg::bombArmed);
		sendRandom(150, 0, 640, 0, 480, 0);
		sweepCross(3, 2, 1'b0);
		drainPipe();
		reportTest(5, "inactive pixels");

		stallOn = 1'b1;
		sweepCross(3, 2, 1'b1);
		sendRandom(400, 0, 640, 0, 480, 2);
		drainPipe();
		stallOn = 1'b0;
		outReady = 1'b1;
		reportTest(6, "back-pressure");

		$display("total: %0d pixels checked, %0d mismatches, %0d assertion failures",
			checkCount, errorCount, UUT.check.failCount);
		if (errorCount == 0 && checkCount > 0 && UUT.check.failCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- tb/mapperChk.sv
// mapperChk: handshake assertions for the colour engine, and the bind into colorMapper
`timescale 1ns/1ps

module mapperChk (
	input logic Clk,
	input logic rstN,
	input mapperPkg::pixelReqT inReq,
	input logic inValid,
	input logic inReady,
	input mapperPkg::rgbT outRgb,
	input logic outValid,
	input logic outReady
);

	// count of failed assertions
	int failCount = 0;

	// nothing leaves the engine while reset is held
	resetQuiet: assert property (@(posedge Clk) !rstN |-> !outValid)
		else begin
			$error("outValid high while reset is held");
			failCount++;
		end

	// stalled output keeps its pixel
	outHold: assert property (@(posedge Clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outRgb))
		else begin
			$error("output pixel changed while stalled");
			failCount++;
		end

	// stimulus side, a waiting request stays put
	inHold: assert property (@(posedge Clk) disable iff (!rstN)
		inValid && !inReady |=> inValid && $stable(inReq))
		else begin
			$error("input request changed while stalled");
			failCount++;
		end

endmodule

bind colorMapper mapperChk check (
	.Clk(Clk),
	.rstN(rstN),
	.inReq(inReq),
	.inValid(inValid),
	.inReady(inReady),
	.outRgb(outRgb),
	.outValid(outValid),
	.outReady(outReady)
);

//--- tb/mapperScoreboard.sv
// mapperScoreboard: reference colour model with its own map, expected queue and output compare
`timescale 1ns/1ps

module mapperScoreboard #(
	parameter int PlayerWidth = 20,
	parameter int PlayerHeight = 27,
	parameter int BombWidth = 15,
	parameter int BombHeight = 18
) (
	input logic Clk,
	input logic rstN,
	output int checkCount,
	output int errorCount,
	output int pending
);

	mapperPkg::tileE refMap [mapperPkg::TileRows][mapperPkg::TileCols];
	mapperPkg::rgbT expQ [$];
	mapperPkg::rgbT expected;
	int pushCount;
	int popCount;

	assign pending = pushCount - popCount;

	// --------------------------------------------------
	// reference rules
	// --------------------------------------------------
	function automatic mapperPkg::tileE startTile(input int col, input int row);
		logic border;
		border = (col == 0) || (row == 0) || (col == mapperPkg::TileCols - 1) ||
			(row == mapperPkg::TileRows - 1);
		if (border || (col % 2 == 0 && row % 2 == 0)) begin
			return mapperPkg::tileWall;
		end
		if (col == mapperPkg::SpeedUpCol && row == mapperPkg::SpeedUpRow) begin
			return mapperPkg::tileSpeedUp;
		end
		if (col == mapperPkg::BombUpCol && row == mapperPkg::BombUpRow) begin
			return mapperPkg::tileBombUp;
		end
		return ((col + row) % 3 == 0) ? mapperPkg::tileBrick : mapperPkg::tileEmpty;
	endfunction

	function automatic logic inBox(input int px, py, ox, oy, w, h);
		return (px >= ox) && (px < ox + w) && (py >= oy) && (py < oy + h);
	endfunction

	// manhattan distance of at most one tile is the cross
	function automatic logic inBlast(input mapperPkg::bombT bomb, input int col, row);
		int dc;
		int dr;
		dc = col - (bomb.x >> mapperPkg::TileShift);
		dr = row - (bomb.y >> mapperPkg::TileShift);
		dc = (dc < 0) ? -dc : dc;
		dr = (dr < 0) ? -dr : dr;
		return (bomb.state == mapperPkg::bombExploding) && (dc + dr <= 1);
	endfunction

	function automatic mapperPkg::rgbT refColor(input mapperPkg::pixelReqT px,
		input mapperPkg::sceneT sc);
		int col;
		int row;
		mapperPkg::tileE tile;
		logic blast;
		col = px.x >> mapperPkg::TileShift;
		row = px.y >> mapperPkg::TileShift;
		tile = refMap[row][col];
		blast = inBlast(sc.bomb1, col, row) || inBlast(sc.bomb2, col, row);
		// bricks only burn during play, and only under an active pixel
		if (px.active && sc.gameState == mapperPkg::gamePlay && blast &&
			tile == mapperPkg::tileBrick) begin
			refMap[row][col] = mapperPkg::tileEmpty;
		end
		if (!px.active) return mapperPkg::ColorBlack;
		if (sc.gameState == mapperPkg::gamePause) begin
			return inBox(px.x, px.y, mapperPkg::BannerX0, mapperPkg::BannerY0,
				mapperPkg::BannerX1 - mapperPkg::BannerX0,
				mapperPkg::BannerY1 - mapperPkg::BannerY0) ?
				mapperPkg::ColorBanner : mapperPkg::ColorBlack;
		end
		if (tile == mapperPkg::tileWall) return mapperPkg::ColorWall;
		if (blast) return mapperPkg::ColorBlast;
		if (tile == mapperPkg::tileBrick) return mapperPkg::ColorBrick;
		if (inBox(px.x, px.y, sc.player1X, sc.player1Y, PlayerWidth, PlayerHeight)) begin
			return mapperPkg::ColorPlayer1;
		end
		if (inBox(px.x, px.y, sc.player2X, sc.player2Y, PlayerWidth, PlayerHeight)) begin
			return mapperPkg::ColorPlayer2;
		end
		if ((sc.bomb1.state == mapperPkg::bombArmed &&
			inBox(px.x, px.y, sc.bomb1.x, sc.bomb1.y, BombWidth, BombHeight)) ||
			(sc.bomb2.state == mapperPkg::bombArmed &&
			inBox(px.x, px.y, sc.bomb2.x, sc.bomb2.y, BombWidth, BombHeight))) begin
			return mapperPkg::ColorBomb;
		end
		if (tile == mapperPkg::tileSpeedUp) return mapperPkg::ColorSpeedUp;
		if (tile == mapperPkg::tileBombUp) return mapperPkg::ColorBombUp;
		return mapperPkg::ColorSky;
	endfunction

	// --------------------------------------------------
	// expected colours, one per accepted request
	// --------------------------------------------------
	always @(posedge Clk) begin
		if (!rstN) begin
			for (int r = 0; r < mapperPkg::TileRows; r++) begin
				for (int c = 0; c < mapperPkg::TileCols; c++) begin
					refMap[r][c] = startTile(c, r);
				end
			end
			expQ.delete();
			pushCount = 0;
		end else if (colorMapperTb.UUT.inValid && colorMapperTb.UUT.inReady) begin
			expQ.push_back(refColor(colorMapperTb.UUT.inReq, colorMapperTb.UUT.scene));
			pushCount++;
		end
	end

	// compare on every output transfer
	always @(posedge Clk) begin
		if (!rstN) begin
			popCount = 0;
			checkCount = 0;
			errorCount = 0;
		end else if (colorMapperTb.UUT.outValid && colorMapperTb.UUT.outReady) begin
			if (expQ.size() == 0) begin
				$display("%0t ns: output pixel arrived with no request left to match it", $time);
				errorCount++;
			end else begin
				expected = expQ.pop_front();
				popCount++;
				checkCount++;
				if (colorMapperTb.UUT.outRgb !== expected) begin
					$display("Mismatch at %0t ns: expected colour %06h, got %06h", $time,
						expected, colorMapperTb.UUT.outRgb);
					errorCount++;
				end
			end
		end
	end

endmodule
